//--- verification/dp_exec_trace.txt
# name issue alu_op set_flags imm_form operand2 rn_value rm_value latch_op_b use_op_b_latch
# disable_op_b, then expected result, write_rd and NZCV flags; every field but the name is hex
add_basic          1 4 1 0 000 00000005 00000003 0 0 0 00000008 1 0
add_carry          1 4 1 0 000 ffffffff 00000001 0 0 0 00000000 1 6
adc_carry_in       1 5 1 0 000 00000010 00000020 0 0 0 00000031 1 0
add_overflow       1 4 1 0 000 7fffffff 00000001 0 0 0 80000000 1 9
sub_no_borrow      1 2 1 0 000 00000009 00000004 0 0 0 00000005 1 2
sub_borrow         1 2 1 0 000 00000003 00000005 0 0 0 fffffffe 1 8
sbc_borrow_in      1 6 1 0 000 00000010 00000004 0 0 0 0000000b 1 2
sub_overflow       1 2 1 0 000 80000000 00000001 0 0 0 7fffffff 1 3
rsb_basic          1 3 1 0 000 00000003 0000000a 0 0 0 00000007 1 2
rsb_borrow         1 3 1 0 000 0000000a 00000003 0 0 0 fffffff9 1 8
rsc_borrow_in      1 7 1 0 000 00000002 00000008 0 0 0 00000005 1 2
adc_wrap           1 5 1 0 000 ffffffff 00000000 0 0 0 00000000 1 6
mov_imm_rot0       1 d 1 1 0ff 00000000 00000000 0 0 0 000000ff 1 2
mov_imm_rot_c0     1 d 1 1 1fc 00000000 00000000 0 0 0 0000003f 1 0
orr_imm_rot_c1     1 c 1 1 4ff 0000000f 00000000 0 0 0 ff00000f 1 a
and_lsl4           1 0 1 0 200 ffffffff f0000001 0 0 0 00000010 1 2
eor_lsr32          1 1 1 0 020 12345678 7fffffff 0 0 0 12345678 1 0
mov_asr32          1 d 1 0 040 00000000 80000000 0 0 0 ffffffff 1 a
mov_rrx            1 d 1 0 060 00000000 00000002 0 0 0 80000001 1 8
bic_lsr8           1 e 1 0 420 ffffffff 0000ff80 0 0 0 ffffff00 1 a
mvn_asr4           1 f 1 0 240 00000000 80000070 0 0 0 07fffff8 1 0
mov_ror8           1 d 1 0 460 00000000 000000a5 0 0 0 a5000000 1 a
add_overflow_2     1 4 1 0 000 7fffffff 7fffffff 0 0 0 fffffffe 1 9
teq_keeps_v        1 9 1 0 000 0000ffff 0000ffff 0 0 0 00000000 0 5
cmp_equal          1 a 1 0 000 00000042 00000042 0 0 0 00000000 0 6
cmp_less           1 a 1 0 000 00000001 00000002 0 0 0 ffffffff 0 8
cmn_carry_ovf      1 b 1 0 000 80000000 80000000 0 0 0 00000000 0 7
tst_imm_rot        1 8 1 1 2f0 000000f0 00000000 0 0 0 00000000 0 5
cmp_no_flags       1 a 0 0 000 00000001 00000005 0 0 0 fffffffc 0 5
tst_no_flags       1 8 0 0 000 ffffffff 80000000 0 0 0 80000000 0 5
add_no_flags       1 4 0 0 000 00000001 00000001 0 0 0 00000002 1 5
latch_capture      0 0 0 0 000 00000000 cafef00d 1 0 0 00000000 0 0
mov_from_latch     1 d 1 0 000 00000000 11111111 0 1 0 cafef00d 1 9
add_from_latch     1 4 1 0 000 00000003 00000005 0 1 0 cafef010 1 8
mov_disable_b      1 d 1 1 0ff 00000000 00000000 0 0 1 00000000 1 4
latch_over_disable 1 4 1 0 000 00000001 00000000 0 1 1 cafef00e 1 8
sub_disable_b      1 2 1 0 000 00000007 00000000 0 0 1 00000007 1 2

//--- dp_exec.f
source/dp_exec_pkg.sv
source/operand_shifter.sv
source/dp_alu.sv
source/exec_writeback.sv
source/dp_exec_top.sv
verification/dp_exec_checker.sv
verification/dp_exec_tb.sv

//--- verification/dp_exec_tb.sv
`timescale 1ns/100ps

module dp_exec_tb import dp_exec_pkg::*; ();

    localparam TRACE_FILE = "verification/dp_exec_trace.txt";
    localparam int DONE_LIMIT = 200;

    logic              clk;
    logic              reset;
    logic              issue;
    logic [3:0]        alu_op;
    logic              set_flags;
    logic              imm_form;
    operand2_t         operand2;
    logic [WORD_W-1:0] rn_value;
    logic [WORD_W-1:0] rm_value;
    logic              latch_op_b;
    logic              use_op_b_latch;
    logic              disable_op_b;
    logic              result_valid;
    logic [WORD_W-1:0] result;
    logic              write_rd;
    logic [3:0]        flags;
    logic              check_done;
    logic [15:0]       fail_total;

    integer            trace_fd;
    integer            fields;
    integer            wait_cycles;
    reg [8*128-1:0]    line_buf;
    reg [8*24-1:0]     test_name;
    logic              t_issue;
    logic [3:0]        t_op;
    logic              t_sf;
    logic              t_imm;
    logic [11:0]       t_op2;
    logic [31:0]       t_rn;
    logic [31:0]       t_rm;
    logic              t_latch;
    logic              t_use;
    logic              t_dis;
    logic [31:0]       ignored;                      // Expected columns left to the checker

    dp_exec_top dp_exec_top_inst (
        .clk            (clk),
        .reset          (reset),
        .issue          (issue),
        .alu_op         (alu_op),
        .set_flags      (set_flags),
        .imm_form       (imm_form),
        .operand2       (operand2),
        .rn_value       (rn_value),
        .rm_value       (rm_value),
        .latch_op_b     (latch_op_b),
        .use_op_b_latch (use_op_b_latch),
        .disable_op_b   (disable_op_b),
        .result_valid   (result_valid),
        .result         (result),
        .write_rd       (write_rd),
        .flags          (flags)
    );

    dp_exec_checker checker_inst (
        .clk          (clk),
        .reset        (reset),
        .issue        (issue),
        .result_valid (result_valid),
        .result       (result),
        .write_rd     (write_rd),
        .flags        (flags),
        .done         (check_done),
        .fail_total   (fail_total)
    );

    task automatic clear_inputs();
        issue          = 1'b0;
        alu_op         = 4'h0;
        set_flags      = 1'b0;
        imm_form       = 1'b0;
        operand2       = '0;
        rn_value       = '0;
        rm_value       = '0;
        latch_op_b     = 1'b0;
        use_op_b_latch = 1'b0;
        disable_op_b   = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        clear_inputs();
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
        repeat (2) @(posedge clk);                   // Leave room for the reset-state check
        trace_fd = $fopen(TRACE_FILE, "r");
        if (trace_fd == 0) begin
            $display("Could not open trace file %0s", TRACE_FILE);
            $display("** FAIL **");
            $finish;
        end else begin
            while (!$feof(trace_fd)) begin
                line_buf = '0;
                fields = $fgets(line_buf, trace_fd);
                fields = $sscanf(line_buf, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                 test_name, t_issue, t_op, t_sf, t_imm, t_op2, t_rn, t_rm,
                                 t_latch, t_use, t_dis, ignored, ignored, ignored);
                if (fields == 14) begin              // Comment and blank lines fall through
                    @(posedge clk);
                    #1;
                    issue          = t_issue;
                    alu_op         = t_op;
                    set_flags      = t_sf;
                    imm_form       = t_imm;
                    operand2       = t_op2;
                    rn_value       = t_rn;
                    rm_value       = t_rm;
                    latch_op_b     = t_latch;
                    use_op_b_latch = t_use;
                    disable_op_b   = t_dis;
                end
            end
            $fclose(trace_fd);
            @(posedge clk);
            #1;
            clear_inputs();
            wait_cycles = 0;
            while (!check_done && wait_cycles < DONE_LIMIT) begin
                @(posedge clk);
                wait_cycles = wait_cycles + 1;
            end
            if (check_done && fail_total == 0) begin
                $display("** PASS **");
            end else begin
                if (!check_done) begin
                    $display("Checker did not finish within %0d cycles", DONE_LIMIT);
                end
                $display("** FAIL **");
            end
            $finish;
        end
    end

endmodule : dp_exec_tb

//--- verification/dp_exec_checker.sv
`timescale 1ns/100ps

module dp_exec_checker import dp_exec_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              issue,
    input  logic              result_valid,
    input  logic [WORD_W-1:0] result,
    input  logic              write_rd,
    input  logic [3:0]        flags,
    output logic              done,
    output logic [15:0]       fail_total
);

    localparam TRACE_FILE = "verification/dp_exec_trace.txt";
    localparam int VALID_LIMIT = 20;

    integer          trace_fd;
    integer          fields;
    integer          cycles;
    integer          pass_count = 0;
    integer          fail_count = 0;
    integer          timing_errors = 0;
    logic            issue_seen = 1'b0;
    logic            aborted;
    reg [8*128-1:0]  line_buf;
    reg [8*24-1:0]   test_name;
    logic            exp_issue;
    logic [31:0]     skip;                           // Stimulus columns
    logic [31:0]     exp_result;
    logic            exp_wr;
    logic [3:0]      exp_flags;

    assign fail_total = 16'(fail_count + timing_errors);

    task automatic compare_outputs(input [8*24-1:0] name, input exp_valid,
                                   input [31:0] exp_res, input exp_wrd, input [3:0] exp_flg);
        logic ok;
        ok = 1'b1;
        if (result_valid !== exp_valid) begin
            $display("CHECK FAILED %0s result_valid expected %b actual %b",
                     name, exp_valid, result_valid);
            ok = 1'b0;
        end
        if (result !== exp_res) begin
            $display("CHECK FAILED %0s result expected %h actual %h", name, exp_res, result);
            ok = 1'b0;
        end
        if (write_rd !== exp_wrd) begin
            $display("CHECK FAILED %0s write_rd expected %b actual %b", name, exp_wrd, write_rd);
            ok = 1'b0;
        end
        if (flags !== exp_flg) begin
            $display("CHECK FAILED %0s flags expected %h actual %h", name, exp_flg, flags);
            ok = 1'b0;
        end
        if (ok) begin
            pass_count = pass_count + 1;
            $display("ok      %0s", name);
        end else begin
            fail_count = fail_count + 1;
        end
    endtask

    // Exactly one cycle from issue to result_valid
    always @(negedge clk) begin
        if (!reset && !done && result_valid !== issue_seen) begin
            $display("result_valid did not follow issue by exactly one cycle at %0t", $time);
            timing_errors = timing_errors + 1;
        end
        issue_seen = issue;
    end

    initial begin
        done    = 1'b0;
        aborted = 1'b0;
        cycles  = 0;
        while (reset !== 1'b0 && cycles < VALID_LIMIT) begin
            @(negedge clk);
            cycles = cycles + 1;
        end
        trace_fd = $fopen(TRACE_FILE, "r");
        if (reset !== 1'b0) begin
            $display("Reset was never released");
            fail_count = fail_count + 1;
        end else if (trace_fd == 0) begin
            $display("Checker could not open trace file %0s", TRACE_FILE);
            fail_count = fail_count + 1;
        end else begin
            compare_outputs("reset_state", 1'b0, 32'h0, 1'b0, 4'h0);
            while (!aborted && !$feof(trace_fd)) begin
                line_buf = '0;
                fields = $fgets(line_buf, trace_fd);
                fields = $sscanf(line_buf, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                 test_name, exp_issue, skip, skip, skip, skip, skip, skip,
                                 skip, skip, skip, exp_result, exp_wr, exp_flags);
                if (fields == 14 && exp_issue) begin
                    cycles = 0;
                    @(negedge clk);
                    while (result_valid !== 1'b1 && cycles < VALID_LIMIT) begin
                        @(negedge clk);
                        cycles = cycles + 1;
                    end
                    if (result_valid !== 1'b1) begin
                        $display("result_valid never arrived for test %0s", test_name);
                        fail_count = fail_count + 1;
                        aborted = 1'b1;
                    end else begin
                        compare_outputs(test_name, 1'b1, exp_result, exp_wr, exp_flags);
                    end
                end
            end
            $fclose(trace_fd);
        end
        @(negedge clk);                              // Timing check after the last result
        @(posedge clk);
        $display("Checks passed: %0d  failed: %0d", pass_count, fail_count + timing_errors);
        done = 1'b1;
    end

endmodule : dp_exec_checker

//--- source/dp_exec_top.sv
`timescale 1ns/100ps

module dp_exec_top import dp_exec_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                issue,
    input  logic [3:0]          alu_op,
    input  logic                set_flags,
    input  logic                imm_form,
    input  operand2_t           operand2,
    input  logic [WORD_W-1:0]   rn_value,
    input  logic [WORD_W-1:0]   rm_value,
    input  logic                latch_op_b,
    input  logic                use_op_b_latch,
    input  logic                disable_op_b,
    output logic                result_valid,
    output logic [WORD_W-1:0]   result,
    output logic                write_rd,
    output logic [3:0]          flags
);

    logic [WORD_W-1:0] shifted_b;
    logic              shifter_carry;
    logic [WORD_W-1:0] alu_result;
    logic [3:0]        alu_flags;

    operand_shifter operand_shifter_inst (
        .operand2      (operand2),
        .imm_form      (imm_form),
        .rm_value      (rm_value),
        .carry_flag    (flags[FLAG_C]),                 // Architectural C feeds RRX
        .shifted_b     (shifted_b),
        .shifter_carry (shifter_carry)
    );

    dp_alu dp_alu_inst (
        .clk            (clk),
        .reset          (reset),
        .alu_op         (alu_op),
        .rn_value       (rn_value),
        .shifted_b      (shifted_b),
        .shifter_carry  (shifter_carry),
        .flags_in       (flags),
        .latch_op_b     (latch_op_b),
        .use_op_b_latch (use_op_b_latch),
        .disable_op_b   (disable_op_b),
        .alu_result     (alu_result),
        .alu_flags      (alu_flags)
    );

    exec_writeback exec_writeback_inst (
        .clk          (clk),
        .reset        (reset),
        .issue        (issue),
        .alu_op       (alu_op),
        .set_flags    (set_flags),
        .alu_result   (alu_result),
        .alu_flags    (alu_flags),
        .result       (result),
        .result_valid (result_valid),
        .write_rd     (write_rd),
        .flags        (flags)
    );

endmodule : dp_exec_top

//--- source/exec_writeback.sv
`timescale 1ns/100ps

module exec_writeback import dp_exec_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                issue,
    input  logic [3:0]          alu_op,
    input  logic                set_flags,
    input  logic [WORD_W-1:0]   alu_result,
    input  logic [3:0]          alu_flags,
    output logic [WORD_W-1:0]   result,
    output logic                result_valid,
    output logic                write_rd,
    output logic [3:0]          flags
);

    logic is_compare;

    // TST, TEQ, CMP and CMN only touch the flags
    assign is_compare = alu_op inside {OP_TST, OP_TEQ, OP_CMP, OP_CMN};

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
            write_rd     <= 1'b0;
            result       <= '0;
            flags        <= '0;
        end else begin
            result_valid <= issue;                      // One cycle after issue
            write_rd     <= issue & ~is_compare;
            if (issue) begin
                result <= alu_result;
                if (set_flags) begin
                    flags <= alu_flags;                 // Seen by the next issue
                end
            end
        end
    end

endmodule : exec_writeback

//--- source/dp_alu.sv
`timescale 1ns/100ps

module dp_alu import dp_exec_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic [3:0]          alu_op,
    input  logic [WORD_W-1:0]   rn_value,
    input  logic [WORD_W-1:0]   shifted_b,
    input  logic                shifter_carry,
    input  logic [3:0]          flags_in,
    input  logic                latch_op_b,
    input  logic                use_op_b_latch,
    input  logic                disable_op_b,
    output logic [WORD_W-1:0]   alu_result,
    output logic [3:0]          alu_flags
);

    logic [WORD_W-1:0] op_b_latch;
    logic [WORD_W-1:0] op_a;
    logic [WORD_W-1:0] op_b;
    logic [WORD_W:0]   sum;
    logic              carry_in;
    logic              c_out;
    logic              v_out;

    always_ff @(posedge clk) begin
        if (reset) begin
            op_b_latch <= '0;
        end else if (latch_op_b) begin
            op_b_latch <= shifted_b;                      // Independent of issue
        end
    end

    assign op_a     = rn_value;
    assign op_b     = use_op_b_latch ? op_b_latch : (disable_op_b ? '0 : shifted_b);
    assign carry_in = flags_in[FLAG_C];

    always_comb begin
        alu_result = '0;
        sum        = '0;
        c_out      = carry_in;
        v_out      = flags_in[FLAG_V];

        case (alu_op)
            OP_AND, OP_TST: begin
                alu_result = op_a & op_b;
                c_out      = shifter_carry;
            end
            OP_EOR, OP_TEQ: begin
                alu_result = op_a ^ op_b;
                c_out      = shifter_carry;
            end
            OP_ORR: begin
                alu_result = op_a | op_b;
                c_out      = shifter_carry;
            end
            OP_MOV: begin
                alu_result = op_b;
                c_out      = shifter_carry;
            end
            OP_BIC: begin
                alu_result = op_a & ~op_b;
                c_out      = shifter_carry;
            end
            OP_MVN: begin
                alu_result = ~op_b;
                c_out      = shifter_carry;
            end

            OP_ADD, OP_CMN, OP_ADC: begin
                sum        = {1'b0, op_a} + {1'b0, op_b}
                           + {{WORD_W{1'b0}}, (alu_op == OP_ADC) & carry_in};
                alu_result = sum[WORD_W-1:0];
                c_out      = sum[WORD_W];
                v_out      = ~(op_a[WORD_W-1] ^ op_b[WORD_W-1])
                           & (op_a[WORD_W-1] ^ alu_result[WORD_W-1]);
            end

            OP_SUB, OP_CMP, OP_SBC: begin
                sum        = {1'b0, op_a} - {1'b0, op_b}
                           - {{WORD_W{1'b0}}, (alu_op == OP_SBC) & ~carry_in};
                alu_result = sum[WORD_W-1:0];
                c_out      = ~sum[WORD_W];                    // NOT borrow
                v_out      = (op_a[WORD_W-1] ^ op_b[WORD_W-1])
                           & (op_a[WORD_W-1] ^ alu_result[WORD_W-1]);
            end

            OP_RSB, OP_RSC: begin                             // b minus a
                sum        = {1'b0, op_b} - {1'b0, op_a}
                           - {{WORD_W{1'b0}}, (alu_op == OP_RSC) & ~carry_in};
                alu_result = sum[WORD_W-1:0];
                c_out      = ~sum[WORD_W];
                v_out      = (op_a[WORD_W-1] ^ op_b[WORD_W-1])
                           & (op_b[WORD_W-1] ^ alu_result[WORD_W-1]);
            end
        endcase
    end

    always_comb begin
        alu_flags         = '0;
        alu_flags[FLAG_N] = alu_result[WORD_W-1];
        alu_flags[FLAG_Z] = (alu_result == '0);
        alu_flags[FLAG_C] = c_out;
        alu_flags[FLAG_V] = v_out;
    end

endmodule : dp_alu

//--- source/operand_shifter.sv
`timescale 1ns/100ps

module operand_shifter import dp_exec_pkg::*; (
    input  operand2_t           operand2,
    input  logic                imm_form,
    input  logic [WORD_W-1:0]   rm_value,
    input  logic                carry_flag,
    output logic [WORD_W-1:0]   shifted_b,
    output logic                shifter_carry
);

    logic [4:0]          rot_amount;
    logic [WORD_W-1:0]   imm_value;
    logic [4:0]          amount;
    logic [2*WORD_W-1:0] rot_pair;
    logic [WORD_W:0]     left_ext;
    logic [WORD_W:0]     right_ext;

    // Immediate form rotates imm8 right by 2*rotate
    assign rot_amount = {operand2.imm.rotate, 1'b0};
    assign rot_pair   = {2{{24'h0, operand2.imm.imm8}}} >> rot_amount;
    assign imm_value  = rot_pair[WORD_W-1:0];

    assign amount = operand2.shifted.shift_amount;

    always_comb begin
        shifted_b     = rm_value;
        shifter_carry = carry_flag;
        left_ext      = '0;
        right_ext     = '0;

        if (imm_form) begin
            shifted_b = imm_value;
            if (operand2.imm.rotate != 4'h0) begin
                shifter_carry = imm_value[WORD_W-1];
            end
        end else begin
            case (operand2.shifted.shift_type)
                SH_LSL: begin
                    if (amount != 5'd0) begin
                        left_ext      = {1'b0, rm_value} << amount;
                        shifted_b     = left_ext[WORD_W-1:0];
                        shifter_carry = left_ext[WORD_W];      // Last bit out the top
                    end
                end

                SH_LSR: begin
                    if (amount == 5'd0) begin               // LSR #32
                        shifted_b     = '0;
                        shifter_carry = rm_value[WORD_W-1];
                    end else begin
                        right_ext     = {rm_value, 1'b0} >> amount;
                        shifted_b     = right_ext[WORD_W:1];
                        shifter_carry = right_ext[0];
                    end
                end

                SH_ASR: begin
                    if (amount == 5'd0) begin               // ASR #32
                        shifted_b     = {WORD_W{rm_value[WORD_W-1]}};
                        shifter_carry = rm_value[WORD_W-1];
                    end else begin
                        right_ext     = $signed({rm_value, 1'b0}) >>> amount;
                        shifted_b     = right_ext[WORD_W:1];
                        shifter_carry = right_ext[0];
                    end
                end

                SH_ROR: begin
                    if (amount == 5'd0) begin               // RRX
                        shifted_b     = {carry_flag, rm_value[WORD_W-1:1]};
                        shifter_carry = rm_value[0];
                    end else begin
                        shifted_b     = (rm_value >> amount) | (rm_value << (6'd32 - amount));
                        shifter_carry = rm_value[amount-5'd1];
                    end
                end
            endcase
        end
    end

endmodule : operand_shifter

//--- source/dp_exec_pkg.sv
package dp_exec_pkg;

    localparam int WORD_W = 32;

    // Data-processing opcodes in ARM encoding order
    localparam logic [3:0] OP_AND = 4'd0;
    localparam logic [3:0] OP_EOR = 4'd1;
    localparam logic [3:0] OP_SUB = 4'd2;
    localparam logic [3:0] OP_RSB = 4'd3;
    localparam logic [3:0] OP_ADD = 4'd4;
    localparam logic [3:0] OP_ADC = 4'd5;
    localparam logic [3:0] OP_SBC = 4'd6;
    localparam logic [3:0] OP_RSC = 4'd7;
    localparam logic [3:0] OP_TST = 4'd8;
    localparam logic [3:0] OP_TEQ = 4'd9;
    localparam logic [3:0] OP_CMP = 4'd10;
    localparam logic [3:0] OP_CMN = 4'd11;
    localparam logic [3:0] OP_ORR = 4'd12;
    localparam logic [3:0] OP_MOV = 4'd13;
    localparam logic [3:0] OP_BIC = 4'd14;
    localparam logic [3:0] OP_MVN = 4'd15;

    // Shift types
    localparam logic [1:0] SH_LSL = 2'd0;
    localparam logic [1:0] SH_LSR = 2'd1;
    localparam logic [1:0] SH_ASR = 2'd2;
    localparam logic [1:0] SH_ROR = 2'd3;

    // Bit positions in the NZCV word
    localparam int FLAG_N = 3;
    localparam int FLAG_Z = 2;
    localparam int FLAG_C = 1;
    localparam int FLAG_V = 0;

    // Operand-two field from instruction bits 11:0
    typedef union packed {
        struct packed {
            logic [3:0] rotate;             // Rotate right by twice this
            logic [7:0] imm8;
        } imm;
        struct packed {
            logic [4:0] shift_amount;
            logic [1:0] shift_type;
            logic       pad;                // Always zero for immediate-amount shifts
            logic [3:0] rm;                 // Carried only as the value comes on rm_value
        } shifted;
    } operand2_t;

endpackage : dp_exec_pkg
